// File: rv_mem_stage.f
+incdir+logic
logic/rv_mem_pkg.sv
logic/access_checker.sv
logic/load_aligner.sv
logic/mem_wb_reg.sv
logic/rv_mem_stage.sv
tb/tb_rv_mem_stage.sv

// File: Bender.yml
package:
  name: rv_mem_stage

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_mem_pkg.sv
      - logic/access_checker.sv
      - logic/load_aligner.sv
      - logic/mem_wb_reg.sv
      - logic/rv_mem_stage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_rv_mem_stage.sv

// File: tb/tb_rv_mem_stage.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module tb_rv_mem_stage;
  import rv_mem_pkg::*;

  localparam int n_trans         = 500;
  localparam int watchdog_cycles = n_trans * 6 + 20;

  logic       clk = 1'b0;
  logic       i_arst_n;
  logic       i_valid;
  mem_req_t   i_req;
  word_t      i_d_mem_rdata;
  logic       i_d_mem_resp;
  word_t      o_d_mem_addr;
  word_t      o_d_mem_wdata;
  logic       o_d_mem_read;
  logic       o_d_mem_write;
  byte_en_t   o_d_mem_byte_enable;
  logic       o_stall;
  wb_result_t o_wb;

  word_t      mem [16];         // Data memory model
  logic       busy      = 1'b0; // Access in progress
  int         wait_left = 0;
  wb_result_t exp_q [$];
  int         n_accepted = 0;
  int         n_checked  = 0;
  logic       accepted   = 1'b0;
  logic       wb_fresh   = 1'b0; // o_wb loaded at the last edge

  // Model of the instruction held in EX/MEM
  mem_req_t   cur_req;
  logic       cur_valid = 1'b0;
  byte_en_t   cur_wmask;

  rv_mem_stage rv_mem_stage_i (
    .clk                 (clk),
    .i_arst_n            (i_arst_n),
    .i_valid             (i_valid),
    .i_req               (i_req),
    .i_d_mem_rdata       (i_d_mem_rdata),
    .i_d_mem_resp        (i_d_mem_resp),
    .o_d_mem_addr        (o_d_mem_addr),
    .o_d_mem_wdata       (o_d_mem_wdata),
    .o_d_mem_read        (o_d_mem_read),
    .o_d_mem_write       (o_d_mem_write),
    .o_d_mem_byte_enable (o_d_mem_byte_enable),
    .o_stall             (o_stall),
    .o_wb                (o_wb)
  );

  always #50 clk = ~clk;

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_value_error(input string what);
    stop_on_failure($sformatf("ERROR at %0d ns: %s", $time, what));
  endtask

  // Trap and lane masks for one instruction
  function automatic void access_rules(input mem_req_t r, output logic trap,
                                       output byte_en_t rmask, output byte_en_t wmask);
    logic [2:0] f3;
    logic [1:0] off;
    int         size;   // Bytes accessed, 0 when not an access
    int         lane;
    byte_en_t   lanes;
    f3    = r.funct3;
    off   = r.alu_out[1:0];
    trap  = 1'b0;
    size  = 0;
    lanes = '0;
    case (r.opcode)
      op_load: begin
        case (f3)
          3'b000, 3'b100: size = 1;
          3'b001, 3'b101: size = 2;
          3'b010:         size = 4;
          default:        trap = 1'b1;
        endcase
      end
      op_store: begin
        case (f3)
          3'b000:  size = 1;
          3'b001:  size = 2;
          3'b010:  size = 4;
          default: trap = 1'b1;
        endcase
      end
      op_br: trap = (f3 == 3'b010) || (f3 == 3'b011);
      op_lui, op_auipc, op_imm, op_reg, op_jal, op_jalr: trap = 1'b0;
      default: trap = 1'b1;   // Unknown opcode
    endcase
    for (lane = 0; lane < 4; lane++) begin
      if (size == 1) lanes[lane] = (lane == off);
      else if (size == 2) lanes[lane] = !off[0] && (lane == off || lane == off + 1);
      else if (size == 4) lanes[lane] = (lane >= off);
    end
    if ((size == 2 && off[0]) || (size == 4 && off != 2'd0)) trap = 1'b1;
    rmask = (r.opcode == op_load) ? lanes : 4'b0000;
    wmask = (r.opcode == op_store) ? lanes : 4'b0000;
  endfunction

  function automatic word_t extract_load(input logic [2:0] f3, input logic [1:0] off,
                                         input word_t w);
    logic [7:0]  b;
    logic [15:0] h;
    word_t       res;
    b = w[8*off +: 8];
    h = off[1] ? w[31:16] : w[15:0];
    case (f3)
      3'b000:  res = {{24{b[7]}}, b};
      3'b100:  res = {24'h0, b};
      3'b001:  res = off[0] ? 32'h0 : {{16{h[15]}}, h};
      3'b101:  res = off[0] ? 32'h0 : {16'h0, h};
      3'b010:  res = w >> (8 * off);   // Zero fill from the top
      default: res = 32'h0;
    endcase
    return res;
  endfunction

  function automatic wb_result_t expected_result(input mem_req_t r, input word_t mem_word);
    wb_result_t e;
    logic       t;
    byte_en_t   rm;
    byte_en_t   wm;
    access_rules(r, t, rm, wm);
    e.valid = 1'b1;
    e.rd    = r.rd;
    e.we    = r.load_regfile;
    e.trap  = t;
    e.rmask = rm;
    e.wmask = wm;
    e.pc    = r.pc;
    case (r.wb_sel)
      sel_alu_out:  e.data = r.alu_out;
      sel_br_en:    e.data = {31'h0, r.br_en};
      sel_u_imm:    e.data = r.imm;
      sel_pc_plus4: e.data = r.pc + `RV_PC_STEP;
      default:      e.data = extract_load(r.funct3, r.alu_out[1:0], mem_word);
    endcase
    return e;
  endfunction

  function automatic mem_req_t random_req();
    mem_req_t r;
    r.valid = 1'($urandom);   // Ignored by the DUT
    case ($urandom_range(0, 13))
      0:       r.opcode = op_lui;
      1:       r.opcode = op_auipc;
      2:       r.opcode = op_imm;
      3:       r.opcode = op_reg;
      4:       r.opcode = op_jal;
      5:       r.opcode = op_jalr;
      6:       r.opcode = op_br;
      7, 8, 9: r.opcode = op_load;
      10, 11:  r.opcode = op_store;
      default: r.opcode = opcode_t'(7'($urandom));   // Mostly illegal
    endcase
    r.funct3       = funct3_u'(3'($urandom));
    r.rd           = 5'($urandom);
    r.load_regfile = 1'($urandom);
    r.mem_read     = (r.opcode == op_load);
    r.mem_write    = (r.opcode == op_store);
    r.wb_sel       = r.mem_read ? sel_load : wb_sel_t'(3'($urandom_range(0, 3)));
    r.alu_out      = $urandom;
    r.rs2_data     = $urandom;
    r.imm          = $urandom;
    r.pc           = $urandom;
    r.br_en        = 1'($urandom);
    return r;
  endfunction

  // Answers one access after 0 to 3 wait cycles
  task automatic serve_memory();
    logic [3:0] idx;
    int         lane;
    idx = o_d_mem_addr[5:2];
    if (i_d_mem_resp) begin
      i_d_mem_resp = 1'b0;   // Access finished at the last edge
      busy         = 1'b0;
    end
    i_d_mem_rdata = $urandom;
    if ((o_d_mem_read || o_d_mem_write) && !busy) begin
      busy      = 1'b1;
      wait_left = $urandom_range(0, 3);
    end
    if (busy) begin
      if (wait_left == 0) begin
        i_d_mem_resp = 1'b1;
        if (o_d_mem_read) i_d_mem_rdata = mem[idx];
        if (o_d_mem_write) begin
          for (lane = 0; lane < 4; lane++) begin
            if (o_d_mem_byte_enable[lane]) mem[idx][8*lane +: 8] = o_d_mem_wdata[8*lane +: 8];
          end
        end
      end else begin
        wait_left--;
      end
    end
  endtask

  task automatic drive_inputs();
    if (accepted || !i_valid) begin   // Otherwise hold while stalled
      i_valid = (n_accepted < n_trans) && ($urandom_range(0, 3) != 0);
      i_req   = random_req();
    end
  endtask

  task automatic check_next_result();
    wb_result_t exp;
    if (exp_q.size() == 0) begin
      stop_on_failure("A result came out with no instruction pending");
    end else begin
      exp = exp_q.pop_front();
      n_checked++;
      assert (o_wb == exp)
        else report_value_error($sformatf("result %0d got %h expected %h",
                                          n_checked, o_wb, exp));
    end
  endtask

  always @(posedge clk) begin
    logic     t;
    byte_en_t rm;
    if (wb_fresh && o_wb.valid) check_next_result();
    if (!o_stall) begin
      cur_req   = i_req;
      cur_valid = i_arst_n && i_valid;
      access_rules(i_req, t, rm, cur_wmask);
      if (cur_valid) begin
        exp_q.push_back(expected_result(i_req, mem[i_req.alu_out[5:2]]));
        n_accepted++;
      end
    end
    accepted = i_arst_n && i_valid && !o_stall;
    wb_fresh = i_arst_n && !o_stall;
  end

  assert property (@(negedge clk) !i_arst_n |-> (!o_wb.valid && !o_wb.we &&
                   !o_d_mem_read && !o_d_mem_write && !o_stall))
    else report_value_error("outputs not idle during reset");

  assert property (@(posedge clk) disable iff (!i_arst_n)
                   o_stall == ((o_d_mem_read || o_d_mem_write) && !i_d_mem_resp))
    else report_value_error("stall does not match strobe and response");

  assert property (@(posedge clk) disable iff (!i_arst_n)
                   o_d_mem_read == (cur_valid && cur_req.mem_read) &&
                   o_d_mem_write == (cur_valid && cur_req.mem_write))
    else report_value_error("memory strobes do not match the held instruction");

  assert property (@(posedge clk) disable iff (!i_arst_n)
                   o_d_mem_addr == {cur_req.alu_out[31:2], 2'b00})
    else report_value_error($sformatf("bad memory address %h", o_d_mem_addr));

  assert property (@(posedge clk) disable iff (!i_arst_n)
                   o_d_mem_byte_enable == cur_wmask)
    else report_value_error($sformatf("byte enable %b expected %b",
                                      o_d_mem_byte_enable, cur_wmask));

  assert property (@(posedge clk) disable iff (!i_arst_n)
                   o_d_mem_write |-> o_d_mem_wdata == cur_req.rs2_data)
    else report_value_error("write data differs from rs2 data");

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_on_failure("Watchdog expired before all results came out, the pipeline hangs");
  end

  initial begin
    int i;
    void'($urandom(10008));
    i_arst_n      = 1'b0;
    i_valid       = 1'b0;
    i_req         = '0;
    i_d_mem_rdata = '0;
    i_d_mem_resp  = 1'b0;
    for (i = 0; i < 16; i++) mem[i] = $urandom;
    repeat (3) @(negedge clk);
    i_arst_n = 1'b1;
    while (n_checked < n_trans) begin
      @(negedge clk);
      serve_memory();
      drive_inputs();
    end
    repeat (4) begin   // Catch duplicated results
      @(negedge clk);
      serve_memory();
      drive_inputs();
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: logic/rv_mem_stage.sv
`timescale 1ns/1ps

module rv_mem_stage (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_valid,
  input  rv_mem_pkg::mem_req_t   i_req,
  input  rv_mem_pkg::word_t      i_d_mem_rdata,
  input  logic                   i_d_mem_resp,
  output rv_mem_pkg::word_t      o_d_mem_addr,
  output rv_mem_pkg::word_t      o_d_mem_wdata,
  output logic                   o_d_mem_read,
  output logic                   o_d_mem_write,
  output rv_mem_pkg::byte_en_t   o_d_mem_byte_enable,
  output logic                   o_stall,
  output rv_mem_pkg::wb_result_t o_wb
);
  import rv_mem_pkg::*;

  mem_req_t ex_mem_q;        // EX/MEM payload
  logic     ex_mem_valid_q;
  mem_req_t ex_mem;          // Payload with the registered valid bit
  logic     stall;
  logic     trap;
  byte_en_t rmask;
  byte_en_t wmask;
  word_t    load_data;

  // Bubble when the upstream has nothing this cycle
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ex_mem_valid_q <= 1'b0;
    end else if (!stall) begin
      ex_mem_valid_q <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_mem_q <= i_req;
    end
  end

  always_comb begin
    ex_mem       = ex_mem_q;
    ex_mem.valid = ex_mem_valid_q;
  end

  // Data memory port
  assign o_d_mem_read        = ex_mem_valid_q && ex_mem_q.mem_read;
  assign o_d_mem_write       = ex_mem_valid_q && ex_mem_q.mem_write;
  assign o_d_mem_addr        = {ex_mem_q.alu_out[31:2], 2'b00};  // Word aligned
  assign o_d_mem_wdata       = ex_mem_q.rs2_data;
  assign o_d_mem_byte_enable = wmask;

  // Hold both registers until the access completes
  assign stall   = (o_d_mem_read || o_d_mem_write) && !i_d_mem_resp;
  assign o_stall = stall;

  access_checker access_checker_i (
    .i_opcode (ex_mem.opcode),
    .i_funct3 (ex_mem.funct3),
    .i_offset (ex_mem.alu_out[1:0]),
    .o_trap   (trap),
    .o_rmask  (rmask),
    .o_wmask  (wmask)
  );

  load_aligner load_aligner_i (
    .i_funct3    (ex_mem.funct3),
    .i_offset    (ex_mem.alu_out[1:0]),
    .i_rdata     (i_d_mem_rdata),
    .o_load_data (load_data)
  );

  mem_wb_reg mem_wb_reg_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_load      (!stall),
    .i_req       (ex_mem),
    .i_load_data (load_data),
    .i_trap      (trap),
    .i_rmask     (rmask),
    .i_wmask     (wmask),
    .o_wb        (o_wb)
  );

endmodule

// File: logic/mem_wb_reg.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module mem_wb_reg (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_load,
  input  rv_mem_pkg::mem_req_t   i_req,
  input  rv_mem_pkg::word_t      i_load_data,
  input  logic                   i_trap,
  input  rv_mem_pkg::byte_en_t   i_rmask,
  input  rv_mem_pkg::byte_en_t   i_wmask,
  output rv_mem_pkg::wb_result_t o_wb
);
  import rv_mem_pkg::*;

  word_t     wb_data;
  logic      valid_q;
  logic      we_q;
  reg_addr_t rd_q;
  word_t     data_q;
  logic      trap_q;
  byte_en_t  rmask_q;
  byte_en_t  wmask_q;
  word_t     pc_q;

  // Write-back value
  always_comb begin
    case (i_req.wb_sel)
      sel_alu_out:  wb_data = i_req.alu_out;
      sel_br_en:    wb_data = {31'b0, i_req.br_en};  // Zero-extended compare result
      sel_u_imm:    wb_data = i_req.imm;
      sel_pc_plus4: wb_data = i_req.pc + `RV_PC_STEP;
      sel_load:     wb_data = i_load_data;
      default:      wb_data = i_req.alu_out;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else if (i_load) begin
      valid_q <= i_req.valid;
      we_q    <= i_req.valid && i_req.load_regfile;  // Bubbles never write
    end
  end

  always_ff @(posedge clk) begin
    if (i_load) begin
      rd_q    <= i_req.rd;
      data_q  <= wb_data;
      trap_q  <= i_trap;
      rmask_q <= i_rmask;
      wmask_q <= i_wmask;
      pc_q    <= i_req.pc;
    end
  end

  always_comb begin
    o_wb.valid = valid_q;
    o_wb.rd    = rd_q;
    o_wb.we    = we_q;
    o_wb.data  = data_q;
    o_wb.trap  = trap_q;
    o_wb.rmask = rmask_q;
    o_wb.wmask = wmask_q;
    o_wb.pc    = pc_q;
  end

endmodule

// File: logic/load_aligner.sv
`timescale 1ns/1ps

module load_aligner (
  input  rv_mem_pkg::funct3_u i_funct3,
  input  logic [1:0]          i_offset,
  input  rv_mem_pkg::word_t   i_rdata,
  output rv_mem_pkg::word_t   o_load_data
);
  import rv_mem_pkg::*;

  word_t shifted;

  // Bring the addressed byte down to lane 0, zero fill above
  assign shifted = i_rdata >> {i_offset, 3'b000};

  always_comb begin
    case (i_funct3.ld)
      lb:  o_load_data = {{24{shifted[7]}}, shifted[7:0]};
      lbu: o_load_data = {24'b0, shifted[7:0]};
      lh: begin
        if (i_offset[0]) begin
          o_load_data = '0;  // Misaligned half
        end else begin
          o_load_data = {{16{shifted[15]}}, shifted[15:0]};
        end
      end
      lhu: begin
        if (i_offset[0]) begin
          o_load_data = '0;
        end else begin
          o_load_data = {16'b0, shifted[15:0]};
        end
      end
      lw:      o_load_data = shifted;  // Nonzero offset keeps the upper bytes only
      default: o_load_data = '0;
    endcase
  end

endmodule

// File: logic/access_checker.sv
`timescale 1ns/1ps

module access_checker (
  input  rv_mem_pkg::opcode_t  i_opcode,
  input  rv_mem_pkg::funct3_u  i_funct3,
  input  logic [1:0]           i_offset,  // Low address bits
  output logic                 o_trap,
  output rv_mem_pkg::byte_en_t o_rmask,
  output rv_mem_pkg::byte_en_t o_wmask
);
  import rv_mem_pkg::*;

  localparam logic [1:0] sz_byte = 2'd0;
  localparam logic [1:0] sz_half = 2'd1;
  localparam logic [1:0] sz_word = 2'd2;

  logic       is_load;
  logic       is_store;
  logic       bad_enc;     // Unknown opcode or illegal funct3
  logic       misaligned;
  logic [1:0] access_size;
  byte_en_t   lane_mask;

  // Classify the instruction and find the access size
  always_comb begin
    is_load     = 1'b0;
    is_store    = 1'b0;
    bad_enc     = 1'b0;
    access_size = sz_byte;
    case (i_opcode)
      op_lui, op_auipc, op_imm, op_reg, op_jal, op_jalr: ;
      op_br: begin
        case (i_funct3.br)
          beq, bne, blt, bge, bltu, bgeu: ;
          default: bad_enc = 1'b1;
        endcase
      end
      op_load: begin
        is_load = 1'b1;
        case (i_funct3.ld)
          lb, lbu: access_size = sz_byte;
          lh, lhu: access_size = sz_half;
          lw:      access_size = sz_word;
          default: bad_enc = 1'b1;
        endcase
      end
      op_store: begin
        is_store = 1'b1;
        case (i_funct3.st)
          sb:      access_size = sz_byte;
          sh:      access_size = sz_half;
          sw:      access_size = sz_word;
          default: bad_enc = 1'b1;
        endcase
      end
      default: bad_enc = 1'b1;
    endcase
  end

  // Byte lanes touched, shared by loads and stores
  always_comb begin
    misaligned = 1'b0;
    case (access_size)
      sz_byte: lane_mask = 4'b0001 << i_offset;
      sz_half: begin
        misaligned = i_offset[0];
        lane_mask  = i_offset[0] ? 4'b0000 : (4'b0011 << i_offset); // Odd offset gives no lanes
      end
      default: begin
        misaligned = |i_offset;
        lane_mask  = 4'b1111 << i_offset;  // Lanes from the offset upward
      end
    endcase
  end

  assign o_rmask = (is_load && !bad_enc) ? lane_mask : 4'b0000;
  assign o_wmask = (is_store && !bad_enc) ? lane_mask : 4'b0000;
  assign o_trap  = bad_enc || ((is_load || is_store) && misaligned);

endmodule

// File: logic/rv_mem_pkg.sv
`include "rv_mem_cfg.svh"

package rv_mem_pkg;

  typedef logic [`RV_XLEN-1:0]       word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`RV_BE_W-1:0]       byte_en_t;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011
  } opcode_t;

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_funct3_t;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // Same funct3 bits, read according to the opcode class
  typedef union packed {
    load_funct3_t   ld;
    store_funct3_t  st;
    branch_funct3_t br;
  } funct3_u;

  // Write-back source
  typedef enum logic [2:0] {
    sel_alu_out  = 3'd0,
    sel_br_en    = 3'd1,
    sel_u_imm    = 3'd2,
    sel_pc_plus4 = 3'd3,
    sel_load     = 3'd4
  } wb_sel_t;

  // One executed instruction entering MEM
  typedef struct packed {
    logic      valid;
    opcode_t   opcode;
    funct3_u   funct3;
    reg_addr_t rd;
    logic      load_regfile;
    logic      mem_read;
    logic      mem_write;
    wb_sel_t   wb_sel;
    word_t     alu_out;     // Result or effective address
    word_t     rs2_data;    // Store data
    word_t     imm;
    word_t     pc;
    logic      br_en;
  } mem_req_t;

  // MEM/WB register contents
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    logic      we;
    word_t     data;
    logic      trap;
    byte_en_t  rmask;
    byte_en_t  wmask;
    word_t     pc;
  } wb_result_t;

endpackage

// File: logic/rv_mem_cfg.svh
`ifndef RV_MEM_CFG_SVH
`define RV_MEM_CFG_SVH

// Datapath and address width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

// One enable bit per byte lane of a data word
`define RV_BE_W 4

// Instruction size, used for the jal/jalr return address
`define RV_PC_STEP 4

`endif
